// ==== list.f ====
source/map_pkg.sv
source/map_dpram.sv
source/map_translate.sv
source/map_loader.sv
source/map_unit.sv
tb/tb_clock.sv
tb/map_unit_tb.sv

// ==== tb/map_unit_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Map unit testbench.
// Random map loads, lookups and mixed traffic against a model of both
// maps that keeps its expected results in order with their due cycle.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module map_unit_tb;

   localparam int clk_period   = 8;
   localparam int n_load_ops   = 300;
   localparam int n_single     = 64;
   localparam int n_fault_rnds = 4;
   localparam int n_b2b        = 200;
   localparam int n_mixed      = 500;
   localparam int watchdog_cycles = 3072 + n_load_ops + 6 * n_single
                                    + 48 * n_fault_rnds + n_b2b + n_mixed + 300;

   logic                              clk_a;
   logic                              reset;
   logic                              lookup;
   logic                              lookup_write;
   logic [map_pkg::vma_width-1:0]     vma;
   logic                              cmd;
   map_pkg::map_op_t                  cmd_op;
   logic [map_pkg::l1_addr_width-1:0] map_addr;
   logic [map_pkg::l2_data_width-1:0] map_wdata;
   logic                              result_valid;
   logic [map_pkg::pa_width-1:0]      phys_addr;
   logic                              access_fault;
   logic                              write_fault;
   logic                              rdata_valid;
   logic [map_pkg::l2_data_width-1:0] rdata;

   // Model of both maps and of the lookup held between the two reads.
   logic [map_pkg::l1_data_width-1:0] l1_model [0:2**map_pkg::l1_addr_width-1];
   logic [map_pkg::l2_data_width-1:0] l2_model [0:2**map_pkg::l2_addr_width-1];
   logic                              m_s1_valid = 1'b0;
   logic                              m_s1_write;
   logic [map_pkg::l1_data_width-1:0] m_s1_block;
   logic [12:0]                       m_s1_low;

   // Expected results with the cycle in which each is due.
   int                                res_due [$];
   logic [map_pkg::pa_width-1:0]      res_pa [$];
   logic [1:0]                        res_flags [$];
   int                                rd_due [$];
   logic [map_pkg::l2_data_width-1:0] rd_data [$];

   int          cycle = 0;
   int          error_count = 0;
   int          errors_at_start = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   string       test_name = "startup";
   logic [31:0] rng_state = 32'haaf7_4b25;

   tb_clock clock0 (.clk_a(clk_a), .reset(reset));

   map_unit dut0
     (.clk_a(clk_a), .reset(reset),
      .lookup(lookup), .lookup_write(lookup_write), .vma(vma),
      .cmd(cmd), .cmd_op(cmd_op), .map_addr(map_addr), .map_wdata(map_wdata),
      .result_valid(result_valid), .phys_addr(phys_addr),
      .access_fault(access_fault), .write_fault(write_fault),
      .rdata_valid(rdata_valid), .rdata(rdata));

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state ^ (rng_state >> 15);  // Low LCG bits are weak.
   endfunction

   task automatic report_error(input string msg);
      $display("error in %s at cycle %0d: %s", test_name, cycle, msg);
      error_count++;
   endtask

   task automatic check_pa(input string test, input logic [map_pkg::pa_width-1:0] expected,
                           input logic [map_pkg::pa_width-1:0] actual);
      if (actual !== expected)
      begin
         $display("mismatch %s phys_addr: expected %h, actual %h", test, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_flags(input string test, input string field,
                              input logic [1:0] expected, input logic [1:0] actual);
      if (actual !== expected)
      begin
         $display("mismatch %s %s: expected %b, actual %b", test, field, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_rdata(input string test,
                              input logic [map_pkg::l2_data_width-1:0] expected,
                              input logic [map_pkg::l2_data_width-1:0] actual);
      if (actual !== expected)
      begin
         $display("mismatch %s rdata: expected %h, actual %h", test, expected, actual);
         error_count++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Model and output monitor, on the falling edge
   //////////////////////////////////////////////////////////////////////

   task automatic check_outputs();
      if (res_due.size() != 0 && res_due[0] == cycle)
      begin
         if (result_valid !== 1'b1)
            report_error("result_valid missing two cycles after a lookup");
         else
         begin
            check_pa(test_name, res_pa[0], phys_addr);
            check_flags(test_name, "faults", res_flags[0], {access_fault, write_fault});
         end
         void'(res_due.pop_front());
         void'(res_pa.pop_front());
         void'(res_flags.pop_front());
      end
      else if (result_valid !== 1'b0)
         report_error("result_valid high with no lookup due");
      if (rd_due.size() != 0 && rd_due[0] == cycle)
      begin
         if (rdata_valid !== 1'b1)
            report_error("rdata_valid missing one cycle after a read command");
         else
            check_rdata(test_name, rd_data[0], rdata);
         void'(rd_due.pop_front());
         void'(rd_data.pop_front());
      end
      else if (rdata_valid !== 1'b0)
         report_error("rdata_valid high with no read due");
   endtask

   // Inputs seen here are sampled at the next edge, so all reads use the
   // arrays before this cycle's write is applied.
   task automatic model_step();
      logic [map_pkg::l2_addr_width-1:0] l2_idx;
      logic [map_pkg::l2_data_width-1:0] entry;
      logic [map_pkg::l2_data_width-1:0] word;
      logic                              acc;
      logic                              wr;
      if (m_s1_valid)
      begin
         l2_idx = {m_s1_block, m_s1_low[12:8]};
         entry  = l2_model[l2_idx];
         acc    = entry[map_pkg::l2_access_bit];
         wr     = entry[map_pkg::l2_write_bit];
         res_due.push_back(cycle + 1);
         res_pa.push_back({entry[map_pkg::ppn_width-1:0], m_s1_low[7:0]});
         res_flags.push_back({~acc, m_s1_write & acc & ~wr});
      end
      m_s1_valid = lookup;
      if (lookup)
      begin
         m_s1_block = l1_model[vma[map_pkg::vma_width-1:13]];
         m_s1_write = lookup_write;
         m_s1_low   = vma[12:0];
      end
      if (cmd)
      begin
         word = '0;
         case (cmd_op)
            map_pkg::op_write_l1 : l1_model[map_addr] = map_wdata[map_pkg::l1_data_width-1:0];
            map_pkg::op_write_l2 : l2_model[map_addr[map_pkg::l2_addr_width-1:0]] = map_wdata;
            map_pkg::op_read_l1 :
            begin
               word[map_pkg::l1_data_width-1:0] = l1_model[map_addr];
               rd_due.push_back(cycle + 1);
               rd_data.push_back(word);
            end
            default :
            begin
               rd_due.push_back(cycle + 1);
               rd_data.push_back(l2_model[map_addr[map_pkg::l2_addr_width-1:0]]);
            end
         endcase
      end
   endtask

   always @(posedge clk_a)
      cycle <= cycle + 1;

   always @(negedge clk_a)
   begin
      if (reset === 1'b0)
      begin
         check_outputs();
         model_step();
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic apply_inputs(input logic lk, input logic lk_wr,
                               input logic [map_pkg::vma_width-1:0] va, input logic c,
                               input map_pkg::map_op_t op,
                               input logic [map_pkg::l1_addr_width-1:0] addr,
                               input logic [map_pkg::l2_data_width-1:0] wd);
      @(posedge clk_a);
      #1;
      lookup       = lk;
      lookup_write = lk_wr;
      vma          = va;
      cmd          = c;
      cmd_op       = op;
      map_addr     = addr;
      map_wdata    = wd;
   endtask

   task automatic idle_cycle();
      apply_inputs(1'b0, 1'b0, '0, 1'b0, map_pkg::op_read_l1, '0, '0);
   endtask

   task automatic wait_drained();
      idle_cycle();
      while (res_due.size() != 0 || rd_due.size() != 0 || m_s1_valid)
         idle_cycle();
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = error_count;
   endtask

   task automatic finish_test();
      int errs;
      errs = error_count - errors_at_start;
      tests_run++;
      if (errs == 0)
         $display("test %s: ok", test_name);
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, errs);
      end
   endtask

   task automatic reset_idle();
      start_test("reset");
      repeat (6)
      begin
         idle_cycle();
         check_flags(test_name, "strobes", 2'b00, {result_valid, rdata_valid});
         check_rdata(test_name, '0, rdata);
      end
      finish_test();
   endtask

   task automatic load_readback();
      logic [31:0] r;
      start_test("load");
      for (int i = 0; i < 2**map_pkg::l1_addr_width; i++)
         apply_inputs(1'b0, 1'b0, '0, 1'b1, map_pkg::op_write_l1, i, next_random());
      for (int i = 0; i < 2**map_pkg::l2_addr_width; i++)
         apply_inputs(1'b0, 1'b0, '0, 1'b1, map_pkg::op_write_l2, i, next_random());
      for (int i = 0; i < n_load_ops; i++)
      begin
         r = next_random();
         apply_inputs(1'b0, 1'b0, '0, 1'b1, map_pkg::map_op_t'(r[31:30]), r[10:0],
                      next_random());
      end
      wait_drained();
      finish_test();
   endtask

   task automatic translate_single();
      logic [31:0] r;
      start_test("translate");
      for (int i = 0; i < n_single; i++)
      begin
         r = next_random();
         apply_inputs(1'b1, r[31], r[23:0], 1'b0, map_pkg::op_read_l1, '0, '0);
         wait_drained();
      end
      finish_test();
   endtask

   task automatic fault_combos();
      logic [map_pkg::vma_width-1:0]     va;
      logic [map_pkg::l2_addr_width-1:0] l2_idx;
      logic [map_pkg::l1_addr_width-1:0] addr;
      logic [map_pkg::l2_data_width-1:0] entry;
      start_test("faults");
      for (int rnd = 0; rnd < n_fault_rnds; rnd++)
      begin
         for (int combo = 0; combo < 8; combo++)
         begin
            va     = next_random();
            l2_idx = {l1_model[va[map_pkg::vma_width-1:13]], va[12:8]};
            addr   = '0;
            addr[map_pkg::l2_addr_width-1:0] = l2_idx;
            entry  = '0;
            entry[map_pkg::l2_access_bit] = combo[1];
            entry[map_pkg::l2_write_bit]  = combo[0];
            entry[map_pkg::ppn_width-1:0] = next_random();
            apply_inputs(1'b0, 1'b0, '0, 1'b1, map_pkg::op_write_l2, addr, entry);
            apply_inputs(1'b1, combo[2], va, 1'b0, map_pkg::op_read_l1, '0, '0);
            wait_drained();
         end
      end
      finish_test();
   endtask

   task automatic back_to_back();
      logic [31:0] r;
      start_test("back_to_back");
      for (int i = 0; i < n_b2b; i++)
      begin
         r = next_random();
         apply_inputs(1'b1, r[31], r[23:0], 1'b0, map_pkg::op_read_l1, '0, '0);
      end
      wait_drained();
      finish_test();
   endtask

   task automatic mixed_traffic();
      logic [31:0]                       r;
      logic [map_pkg::vma_width-1:0]     va;
      logic [map_pkg::vma_width-1:0]     prev_va;
      logic                              prev_lk;
      logic                              lk;
      map_pkg::map_op_t                  op;
      logic [map_pkg::l1_addr_width-1:0] addr;
      start_test("mixed");
      prev_lk = 1'b0;
      prev_va = '0;
      for (int i = 0; i < n_mixed; i++)
      begin
         r    = next_random();
         va   = next_random();
         lk   = r[31] | r[30];
         op   = map_pkg::map_op_t'(r[29:28]);
         addr = r[10:0];
         // Aim some writes at the entry read at the same edge.
         if (r[27:26] == 2'b00 && lk)
         begin
            op   = map_pkg::op_write_l1;
            addr = va[map_pkg::vma_width-1:13];
         end
         else if (r[27:26] == 2'b01 && prev_lk)
         begin
            op   = map_pkg::op_write_l2;
            addr = {1'b0, l1_model[prev_va[map_pkg::vma_width-1:13]], prev_va[12:8]};
         end
         apply_inputs(lk, r[25], va, r[24] | r[23], op, addr, next_random());
         prev_lk = lk;
         prev_va = va;
      end
      wait_drained();
      finish_test();
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence and watchdog
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      lookup       = 1'b0;
      lookup_write = 1'b0;
      vma          = '0;
      cmd          = 1'b0;
      cmd_op       = map_pkg::op_read_l1;
      map_addr     = '0;
      map_wdata    = '0;
      wait (reset === 1'b0);
      reset_idle();
      load_readback();
      translate_single();
      fault_combos();
      back_to_back();
      mixed_traffic();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
      if (error_count == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      #(watchdog_cycles * clk_period);
      $display("timeout: run still going after %0d cycles in test %s",
               watchdog_cycles, test_name);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset.
// Free-running 8 ns clock, with reset held for the first 3 cycles.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_clock
  (
   output logic clk_a,
   output logic reset
   );

   localparam int half_period = 4;

   initial
   begin
      clk_a = 1'b0;
      forever #half_period clk_a = ~clk_a;
   end

   initial
   begin
      reset = 1'b1;
      repeat (3) @(posedge clk_a);
      #1 reset = 1'b0;  // Released with the other inputs.
   end

endmodule

`default_nettype wire

// ==== source/map_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Virtual memory map unit.
// Both map RAMs with the translator on port A and the loader on
// port B.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module map_unit
  (
   input  wire logic                              clk_a,
   input  wire logic                              reset,

   input  wire logic                              lookup,
   input  wire logic                              lookup_write,
   input  wire logic [map_pkg::vma_width-1:0]     vma,

   input  wire logic                              cmd,
   input  wire map_pkg::map_op_t                  cmd_op,
   input  wire logic [map_pkg::l1_addr_width-1:0] map_addr,
   input  wire logic [map_pkg::l2_data_width-1:0] map_wdata,

   output logic                                   result_valid,
   output logic      [map_pkg::pa_width-1:0]      phys_addr,
   output logic                                   access_fault,
   output logic                                   write_fault,

   output logic                                   rdata_valid,
   output logic      [map_pkg::l2_data_width-1:0] rdata
   );

   // Translator side, port A.
   logic                              tr_l1_rden;
   logic [map_pkg::l1_addr_width-1:0] tr_l1_addr;
   logic [map_pkg::l1_data_width-1:0] l1_q_a;
   logic                              tr_l2_rden;
   logic [map_pkg::l2_addr_width-1:0] tr_l2_addr;
   logic [map_pkg::l2_data_width-1:0] l2_q_a;

   // Loader side, port B.
   logic                              ld_l1_rden;
   logic                              ld_l1_wren;
   logic [map_pkg::l1_addr_width-1:0] ld_l1_addr;
   logic [map_pkg::l1_data_width-1:0] ld_l1_wdata;
   logic [map_pkg::l1_data_width-1:0] l1_q_b;
   logic                              ld_l2_rden;
   logic                              ld_l2_wren;
   logic [map_pkg::l2_addr_width-1:0] ld_l2_addr;
   logic [map_pkg::l2_data_width-1:0] ld_l2_wdata;
   logic [map_pkg::l2_data_width-1:0] l2_q_b;

   map_dpram #(.addr_width(map_pkg::l1_addr_width), .data_width(map_pkg::l1_data_width))
      l1_map0 (.clk_a(clk_a), .reset(reset),
               .rden_a(tr_l1_rden), .address_a(tr_l1_addr), .q_a(l1_q_a),
               .rden_b(ld_l1_rden), .wren_b(ld_l1_wren), .address_b(ld_l1_addr),
               .data_b(ld_l1_wdata), .q_b(l1_q_b));

   map_dpram #(.addr_width(map_pkg::l2_addr_width), .data_width(map_pkg::l2_data_width))
      l2_map0 (.clk_a(clk_a), .reset(reset),
               .rden_a(tr_l2_rden), .address_a(tr_l2_addr), .q_a(l2_q_a),
               .rden_b(ld_l2_rden), .wren_b(ld_l2_wren), .address_b(ld_l2_addr),
               .data_b(ld_l2_wdata), .q_b(l2_q_b));

   map_translate translate0
     (.clk_a(clk_a), .reset(reset),
      .lookup(lookup), .lookup_write(lookup_write), .vma(vma),
      .l1_rden(tr_l1_rden), .l1_addr(tr_l1_addr), .l1_q(l1_q_a),
      .l2_rden(tr_l2_rden), .l2_addr(tr_l2_addr), .l2_q(l2_q_a),
      .result_valid(result_valid), .phys_addr(phys_addr),
      .access_fault(access_fault), .write_fault(write_fault));

   map_loader loader0
     (.clk_a(clk_a), .reset(reset),
      .cmd(cmd), .cmd_op(cmd_op), .map_addr(map_addr), .map_wdata(map_wdata),
      .l1_rden(ld_l1_rden), .l1_wren(ld_l1_wren), .l1_addr(ld_l1_addr),
      .l1_wdata(ld_l1_wdata),
      .l2_rden(ld_l2_rden), .l2_wren(ld_l2_wren), .l2_addr(ld_l2_addr),
      .l2_wdata(ld_l2_wdata),
      .l1_q(l1_q_b), .l2_q(l2_q_b),
      .rdata_valid(rdata_valid), .rdata(rdata));

endmodule

`default_nettype wire

// ==== source/map_loader.sv ====
//////////////////////////////////////////////////////////////////////
// Map loader.
// Turns processor map commands into port-B writes and reads of the
// two map RAMs and returns read-back data one cycle after a read.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module map_loader
  (
   input  wire logic                              clk_a,
   input  wire logic                              reset,

   input  wire logic                              cmd,
   input  wire map_pkg::map_op_t                  cmd_op,
   input  wire logic [map_pkg::l1_addr_width-1:0] map_addr,
   input  wire logic [map_pkg::l2_data_width-1:0] map_wdata,

   // Level-one map, port B.
   output logic                                   l1_rden,
   output logic                                   l1_wren,
   output logic      [map_pkg::l1_addr_width-1:0] l1_addr,
   output logic      [map_pkg::l1_data_width-1:0] l1_wdata,

   // Level-two map, port B.
   output logic                                   l2_rden,
   output logic                                   l2_wren,
   output logic      [map_pkg::l2_addr_width-1:0] l2_addr,
   output logic      [map_pkg::l2_data_width-1:0] l2_wdata,

   input  wire logic [map_pkg::l1_data_width-1:0] l1_q,
   input  wire logic [map_pkg::l2_data_width-1:0] l2_q,

   output logic                                   rdata_valid,
   output logic      [map_pkg::l2_data_width-1:0] rdata
   );

   logic rd_pending;
   logic rd_from_l2;

   //////////////////////////////////////////////////////////////////////
   // Command decode
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      l1_rden = 1'b0;
      l1_wren = 1'b0;
      l2_rden = 1'b0;
      l2_wren = 1'b0;
      if (cmd)
      begin
         case (cmd_op)
            map_pkg::op_write_l1 : l1_wren = 1'b1;
            map_pkg::op_write_l2 : l2_wren = 1'b1;
            map_pkg::op_read_l1  : l1_rden = 1'b1;
            map_pkg::op_read_l2  : l2_rden = 1'b1;
            default              : ;
         endcase
      end
   end

   assign l1_addr  = map_addr;
   assign l2_addr  = map_addr[map_pkg::l2_addr_width-1:0];  // Low bits only.
   assign l1_wdata = map_wdata[map_pkg::l1_data_width-1:0];
   assign l2_wdata = map_wdata;

   //////////////////////////////////////////////////////////////////////
   // Read-back
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         rd_pending <= 1'b0;
         rd_from_l2 <= 1'b0;
      end
      else
      begin
         rd_pending <= l1_rden | l2_rden;
         if (l1_rden | l2_rden)
            rd_from_l2 <= l2_rden;
      end
   end

   assign rdata_valid = rd_pending;
   assign rdata = rd_from_l2 ? l2_q :
                  {{(map_pkg::l2_data_width - map_pkg::l1_data_width){1'b0}}, l1_q};

   a_op_known : assert property (
      @(posedge clk_a) disable iff (reset)
      cmd |-> !$isunknown(cmd_op))
      else $error("map_loader command with unknown opcode");

endmodule

`default_nettype wire

// ==== source/map_translate.sv ====
//////////////////////////////////////////////////////////////////////
// Virtual to physical address translator.
// Two-stage pipeline over the level-one and level-two maps. A lookup
// returns the physical address and the fault flags exactly two cycles
// later, and a new lookup may start every cycle.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module map_translate
  (
   input  wire logic                              clk_a,
   input  wire logic                              reset,

   input  wire logic                              lookup,
   input  wire logic                              lookup_write,
   input  wire logic [map_pkg::vma_width-1:0]     vma,

   // Level-one map, port A.
   output logic                                   l1_rden,
   output logic      [map_pkg::l1_addr_width-1:0] l1_addr,
   input  wire logic [map_pkg::l1_data_width-1:0] l1_q,

   // Level-two map, port A.
   output logic                                   l2_rden,
   output logic      [map_pkg::l2_addr_width-1:0] l2_addr,
   input  wire logic [map_pkg::l2_data_width-1:0] l2_q,

   output logic                                   result_valid,
   output logic      [map_pkg::pa_width-1:0]      phys_addr,
   output logic                                   access_fault,
   output logic                                   write_fault
   );

   // Stage one holds the lookup while level one is read.
   logic        s1_valid;
   logic        s1_write;
   logic [12:0] s1_low;

   // Stage two holds it while level two is read.
   logic                             s2_valid;
   logic                             s2_write;
   logic [map_pkg::offset_width-1:0] s2_offset;

   logic access_bit;
   logic write_bit;

   //////////////////////////////////////////////////////////////////////
   // Stage one
   //////////////////////////////////////////////////////////////////////

   assign l1_rden = lookup;
   assign l1_addr = vma[map_pkg::vma_width-1:13];

   always_ff @(posedge clk_a)
   begin
      if (reset)
         s1_valid <= 1'b0;
      else
         s1_valid <= lookup;
   end

   always_ff @(posedge clk_a)
   begin
      s1_write <= lookup_write;
      s1_low   <= vma[12:0];
   end

   //////////////////////////////////////////////////////////////////////
   // Stage two
   //////////////////////////////////////////////////////////////////////

   assign l2_rden = s1_valid;
   assign l2_addr = {l1_q, s1_low[12:8]};  // Block number and page within block.

   always_ff @(posedge clk_a)
   begin
      if (reset)
         s2_valid <= 1'b0;
      else
         s2_valid <= s1_valid;
   end

   always_ff @(posedge clk_a)
   begin
      s2_write  <= s1_write;
      s2_offset <= s1_low[map_pkg::offset_width-1:0];
   end

   //////////////////////////////////////////////////////////////////////
   // Output decode
   //////////////////////////////////////////////////////////////////////

   assign access_bit = l2_q[map_pkg::l2_access_bit];
   assign write_bit  = l2_q[map_pkg::l2_write_bit];

   assign result_valid = s2_valid;
   assign phys_addr    = {l2_q[map_pkg::ppn_width-1:0], s2_offset};

   assign access_fault = s2_valid & ~access_bit;
   assign write_fault  = s2_valid & s2_write & access_bit & ~write_bit;  // Read-only page.

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   a_vma_known : assert property (
      @(posedge clk_a) disable iff (reset)
      lookup |-> !$isunknown(vma))
      else $error("map_translate lookup with unknown address");

endmodule

`default_nettype wire

// ==== source/map_dpram.sv ====
//////////////////////////////////////////////////////////////////////
// Dual-port synchronous map RAM.
// Single clock. Port A reads only, port B reads and writes. Both read
// outputs are registered, hold until the next enabled read and are
// cleared by reset. A read that collides with a write sees old data.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module map_dpram
  #(
   parameter int addr_width = 11,
   parameter int data_width = 5
   )
  (
   input  wire logic                  clk_a,
   input  wire logic                  reset,

   // Port A, lookup side.
   input  wire logic                  rden_a,
   input  wire logic [addr_width-1:0] address_a,
   output logic      [data_width-1:0] q_a,

   // Port B, loader side.
   input  wire logic                  rden_b,
   input  wire logic                  wren_b,
   input  wire logic [addr_width-1:0] address_b,
   input  wire logic [data_width-1:0] data_b,
   output logic      [data_width-1:0] q_b
   );

   logic [data_width-1:0] mem [0:2**addr_width-1];

   always_ff @(posedge clk_a)
   begin
      if (wren_b)
      begin
         mem[address_b] <= data_b;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= mem[address_a];  // Old data on a port-B write.
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= mem[address_b];
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   a_addr_a_known : assert property (
      @(posedge clk_a) disable iff (reset)
      rden_a |-> !$isunknown(address_a))
      else $error("map_dpram port A read with unknown address");

   a_addr_b_known : assert property (
      @(posedge clk_a) disable iff (reset)
      (rden_b || wren_b) |-> !$isunknown(address_b))
      else $error("map_dpram port B access with unknown address");

endmodule

`default_nettype wire

// ==== source/map_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Virtual memory map definitions.
// Address, entry and page widths of the two-level map, the field
// positions inside a level-two entry and the loader command codes.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package map_pkg;

   //////////////////////////////////////////////////////////////////////
   // Address geometry
   //////////////////////////////////////////////////////////////////////

   localparam int vma_width    = 24;   // Virtual word address.
   localparam int pa_width     = 22;   // Physical word address.
   localparam int ppn_width    = 14;   // Physical page number.
   localparam int offset_width = 8;    // Word offset within a page.

   // Level one is indexed by vma[23:13] and holds a 5-bit block number.
   localparam int l1_addr_width = 11;
   localparam int l1_data_width = 5;

   // Level two is indexed by the block number joined with vma[12:8].
   localparam int l2_addr_width = 10;
   localparam int l2_data_width = 24;

   //////////////////////////////////////////////////////////////////////
   // Level-two entry fields
   //////////////////////////////////////////////////////////////////////

   localparam int l2_access_bit = 23;  // Page may be accessed.
   localparam int l2_write_bit  = 22;  // Page may be written.
   // Bits 21 to 14 are unused, the page number sits in bits 13 to 0.

   //////////////////////////////////////////////////////////////////////
   // Loader commands
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      op_write_l1 = 2'b00,
      op_write_l2 = 2'b01,
      op_read_l1  = 2'b10,
      op_read_l2  = 2'b11
   } map_op_t;

endpackage

`default_nettype wire
